// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := dmem_subsys_tb
FILELIST := dmem_subsys_top.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: dmem_subsys_top.f
hdl/dmem_pkg.sv
hdl/dmem_decode.sv
hdl/dmem_tcm.sv
hdl/dmem_timer.sv
hdl/dmem_resp_merge.sv
hdl/dmem_subsys_top.sv
tb/dmem_subsys_properties.sv
tb/dmem_subsys_tb.sv

// File: hdl/dmem_decode.sv
// Registered address decode stage; steers core requests to TCM, timer or external port.
`default_nettype none

module dmem_decode
	import dmem_pkg::*;
#(
	parameter dmem_addr_t  TCM_MASK      = DMEM_TCM_MASK_DEF,
	parameter dmem_addr_t  TCM_PATTERN   = DMEM_TCM_PATTERN_DEF,
	parameter dmem_addr_t  TIMER_MASK    = DMEM_TIMER_MASK_DEF,
	parameter dmem_addr_t  TIMER_PATTERN = DMEM_TIMER_PATTERN_DEF,
	parameter int unsigned OUTSTANDING   = DMEM_OUTSTANDING_DEF
) (
	input  wire        clk,
	input  wire        core_rst_n_local,
	input  wire        req_valid_i,
	input  dmem_req_t  req_i,
	output logic       req_ready_o,
	output dmem_req_t  tgt_req_o,
	output logic       tcm_valid_o,
	output logic       timer_valid_o,
	output logic       ext_valid_o,
	input  wire        tcm_ready_i,
	input  wire        timer_ready_i,
	input  wire        ext_ready_i,
	output logic       tag_push_o,
	output dmem_port_e tag_o,
	input  wire        tag_full_i
);

	logic       aligned;
	dmem_port_e port_sel;
	logic       req_fire;
	logic       out_valid_q;
	dmem_port_e out_port_q;
	dmem_req_t  out_req_q;
	logic       tgt_ready;
	logic       out_fire;

	// the merge FIFO pointers need at least one address bit.
	if (OUTSTANDING < 2) begin : g_depth_check
		$error("dmem_decode: OUTSTANDING must be 2 or more");
	end

	always_comb begin
		case (req_i.width)
			DMEM_WIDTH_BYTE: aligned = 1'b1;
			DMEM_WIDTH_HALF: aligned = ~req_i.addr[0];
			DMEM_WIDTH_WORD: aligned = (req_i.addr[1:0] == 2'b00);
			default:         aligned = 1'b0;
		endcase
		if (!aligned) port_sel = DMEM_PORT_NONE;
		else if ((req_i.addr & TIMER_MASK) == TIMER_PATTERN) port_sel = DMEM_PORT_TIMER;
		else if ((req_i.addr & TCM_MASK) == TCM_PATTERN) port_sel = DMEM_PORT_TCM;
		else port_sel = DMEM_PORT_EXT;
	end

	always_comb begin
		case (out_port_q)
			DMEM_PORT_TCM:   tgt_ready = tcm_ready_i;
			DMEM_PORT_TIMER: tgt_ready = timer_ready_i;
			default:         tgt_ready = ext_ready_i;
		endcase
	end

	assign out_fire    = out_valid_q & tgt_ready;
	assign req_ready_o = (~out_valid_q | out_fire) & ~tag_full_i;
	assign req_fire    = req_valid_i & req_ready_o;
	assign tag_push_o  = req_fire; // tag order is acceptance order.
	assign tag_o       = port_sel;

	always_ff @(posedge clk) begin
		if (!core_rst_n_local) begin
			out_valid_q <= 1'b0;
		end else if (req_fire && port_sel != DMEM_PORT_NONE) begin
			out_valid_q <= 1'b1;
		end else if (out_fire) begin
			out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire && port_sel != DMEM_PORT_NONE) begin
			out_req_q  <= req_i;
			out_port_q <= port_sel;
		end
	end

	assign tgt_req_o     = out_req_q;
	assign tcm_valid_o   = out_valid_q & (out_port_q == DMEM_PORT_TCM);
	assign timer_valid_o = out_valid_q & (out_port_q == DMEM_PORT_TIMER);
	assign ext_valid_o   = out_valid_q & (out_port_q == DMEM_PORT_EXT);

endmodule

`default_nettype wire

// File: hdl/dmem_pkg.sv
// Shared types, encodings and default address map; modules pull it in by wildcard import.
`default_nettype none

package dmem_pkg;

	typedef logic [31:0] dmem_addr_t;
	typedef logic [31:0] dmem_data_t;
	typedef logic [4:0]  dmem_tmr_off_t; // byte offset inside the timer window.

	typedef enum logic {
		DMEM_CMD_RD = 1'b0,
		DMEM_CMD_WR = 1'b1
	} dmem_cmd_e;

	typedef enum logic [1:0] {
		DMEM_WIDTH_BYTE = 2'b00,
		DMEM_WIDTH_HALF = 2'b01,
		DMEM_WIDTH_WORD = 2'b10
	} dmem_width_e;

	typedef enum logic {
		DMEM_RESP_OK  = 1'b0,
		DMEM_RESP_ERR = 1'b1
	} dmem_resp_e;

	typedef enum logic [1:0] {
		DMEM_PORT_EXT   = 2'd0,
		DMEM_PORT_TCM   = 2'd1,
		DMEM_PORT_TIMER = 2'd2,
		DMEM_PORT_NONE  = 2'd3 // misaligned request, answered by the merge stage.
	} dmem_port_e;

	typedef struct packed {
		dmem_cmd_e   cmd;
		dmem_width_e width;
		dmem_addr_t  addr;
		dmem_data_t  wdata; // byte and half data sit in the low lanes.
	} dmem_req_t;

	typedef struct packed {
		dmem_data_t rdata;
		dmem_resp_e resp;
	} dmem_rsp_t;

	localparam dmem_addr_t DMEM_TCM_MASK_DEF      = 32'hFFFF_0000;
	localparam dmem_addr_t DMEM_TCM_PATTERN_DEF   = 32'hF000_0000;
	localparam dmem_addr_t DMEM_TIMER_MASK_DEF    = 32'hFFFF_FFE0;
	localparam dmem_addr_t DMEM_TIMER_PATTERN_DEF = 32'hF004_0000;
	localparam int unsigned DMEM_OUTSTANDING_DEF  = 4;

	localparam dmem_tmr_off_t DMEM_TMR_CTRL     = 5'h00;
	localparam dmem_tmr_off_t DMEM_TMR_MTIME_LO = 5'h08;
	localparam dmem_tmr_off_t DMEM_TMR_MTIME_HI = 5'h0C;
	localparam dmem_tmr_off_t DMEM_TMR_CMP_LO   = 5'h10;
	localparam dmem_tmr_off_t DMEM_TMR_CMP_HI   = 5'h14;

endpackage

`default_nettype wire

// File: hdl/dmem_resp_merge.sv
// In-order response collector; a FIFO of port tags picks which target answers the core next.
`default_nettype none

module dmem_resp_merge
	import dmem_pkg::*;
#(
	parameter int unsigned OUTSTANDING = DMEM_OUTSTANDING_DEF
) (
	input  wire        clk,
	input  wire        core_rst_n_local,
	input  wire        tag_push_i,
	input  dmem_port_e tag_i,
	output logic       tag_full_o,
	input  wire        tcm_rsp_valid_i,
	input  dmem_rsp_t  tcm_rsp_i,
	output logic       tcm_rsp_ready_o,
	input  wire        timer_rsp_valid_i,
	input  dmem_rsp_t  timer_rsp_i,
	output logic       timer_rsp_ready_o,
	input  wire        ext_rsp_valid_i,
	input  dmem_rsp_t  ext_rsp_i,
	output logic       ext_rsp_ready_o,
	output logic       rsp_valid_o,
	output dmem_rsp_t  rsp_o,
	input  wire        rsp_ready_i
);

	localparam int unsigned PTR_W = $clog2(OUTSTANDING);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(OUTSTANDING - 1);

	dmem_port_e       tags_q [OUTSTANDING];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [PTR_W:0]   count_q;
	logic             empty;
	logic             pop;
	dmem_port_e       head;

	assign empty      = (count_q == '0);
	assign tag_full_o = (count_q == (PTR_W+1)'(OUTSTANDING));
	assign head       = tags_q[rd_ptr_q];
	assign pop        = rsp_valid_o & rsp_ready_i;

	// ========================================================================
	// head selection
	// ========================================================================
	always_comb begin
		rsp_valid_o       = 1'b0;
		rsp_o             = '0;
		tcm_rsp_ready_o   = 1'b0;
		timer_rsp_ready_o = 1'b0;
		ext_rsp_ready_o   = 1'b0;
		if (!empty) begin
			case (head)
				DMEM_PORT_TCM: begin
					rsp_valid_o     = tcm_rsp_valid_i;
					rsp_o           = tcm_rsp_i;
					tcm_rsp_ready_o = rsp_ready_i;
				end
				DMEM_PORT_TIMER: begin
					rsp_valid_o       = timer_rsp_valid_i;
					rsp_o             = timer_rsp_i;
					timer_rsp_ready_o = rsp_ready_i;
				end
				DMEM_PORT_EXT: begin
					rsp_valid_o     = ext_rsp_valid_i;
					rsp_o           = ext_rsp_i;
					ext_rsp_ready_o = rsp_ready_i;
				end
				default: begin
					rsp_valid_o = 1'b1; // rejected request, no target involved.
					rsp_o.resp  = DMEM_RESP_ERR;
				end
			endcase
		end
	end

	// ========================================================================
	// tag FIFO
	// ========================================================================
	always_ff @(posedge clk) begin
		if (tag_push_i) tags_q[wr_ptr_q] <= tag_i;
	end

	always_ff @(posedge clk) begin
		if (!core_rst_n_local) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (tag_push_i) wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
			if (pop) rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
			if (tag_push_i && !pop) count_q <= count_q + 1'b1;
			else if (pop && !tag_push_i) count_q <= count_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hdl/dmem_subsys_top.sv
// Data-memory subsystem top; holds the address map and connects decode, targets and merge.
`default_nettype none

module dmem_subsys_top
	import dmem_pkg::*;
#(
	parameter dmem_addr_t  TCM_MASK      = DMEM_TCM_MASK_DEF,
	parameter dmem_addr_t  TCM_PATTERN   = DMEM_TCM_PATTERN_DEF,
	parameter dmem_addr_t  TIMER_MASK    = DMEM_TIMER_MASK_DEF,
	parameter dmem_addr_t  TIMER_PATTERN = DMEM_TIMER_PATTERN_DEF,
	parameter int unsigned OUTSTANDING   = DMEM_OUTSTANDING_DEF
) (
	input  wire       clk,
	input  wire       core_rst_n_local,
	input  wire       req_valid_i,
	output logic      req_ready_o,
	input  dmem_req_t req_i,
	output logic      rsp_valid_o,
	input  wire       rsp_ready_i,
	output dmem_rsp_t rsp_o,
	output logic      ext_req_valid_o,
	input  wire       ext_req_ready_i,
	output dmem_req_t ext_req_o,
	input  wire       ext_rsp_valid_i,
	output logic      ext_rsp_ready_o,
	input  dmem_rsp_t ext_rsp_i,
	output logic      timer_irq_o
);

	localparam int unsigned TCM_DEPTH = int'((~TCM_MASK + 32'd1) >> 2); // region size in words.

	dmem_req_t  tgt_req;
	logic       tcm_valid;
	logic       tcm_ready;
	logic       timer_valid;
	logic       timer_ready;
	logic       tag_push;
	dmem_port_e tag;
	logic       tag_full;
	logic       tcm_rsp_valid;
	dmem_rsp_t  tcm_rsp;
	logic       tcm_rsp_ready;
	logic       timer_rsp_valid;
	dmem_rsp_t  timer_rsp;
	logic       timer_rsp_ready;

	assign ext_req_o = tgt_req;

	// ========================================================================
	// request side
	// ========================================================================
	dmem_decode #(
		.TCM_MASK(TCM_MASK),
		.TCM_PATTERN(TCM_PATTERN),
		.TIMER_MASK(TIMER_MASK),
		.TIMER_PATTERN(TIMER_PATTERN),
		.OUTSTANDING(OUTSTANDING)
	) i_decode (
		.clk(clk),
		.core_rst_n_local(core_rst_n_local),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.req_ready_o(req_ready_o),
		.tgt_req_o(tgt_req),
		.tcm_valid_o(tcm_valid),
		.timer_valid_o(timer_valid),
		.ext_valid_o(ext_req_valid_o),
		.tcm_ready_i(tcm_ready),
		.timer_ready_i(timer_ready),
		.ext_ready_i(ext_req_ready_i),
		.tag_push_o(tag_push),
		.tag_o(tag),
		.tag_full_i(tag_full)
	);

	dmem_tcm #(.DEPTH(TCM_DEPTH)) i_tcm (
		.clk(clk),
		.core_rst_n_local(core_rst_n_local),
		.req_valid_i(tcm_valid),
		.req_i(tgt_req),
		.req_ready_o(tcm_ready),
		.rsp_valid_o(tcm_rsp_valid),
		.rsp_o(tcm_rsp),
		.rsp_ready_i(tcm_rsp_ready)
	);

	dmem_timer i_timer (
		.clk(clk),
		.core_rst_n_local(core_rst_n_local),
		.req_valid_i(timer_valid),
		.req_i(tgt_req),
		.req_ready_o(timer_ready),
		.rsp_valid_o(timer_rsp_valid),
		.rsp_o(timer_rsp),
		.rsp_ready_i(timer_rsp_ready),
		.timer_irq_o(timer_irq_o)
	);

	// ========================================================================
	// response side
	// ========================================================================
	dmem_resp_merge #(.OUTSTANDING(OUTSTANDING)) i_merge (
		.clk(clk),
		.core_rst_n_local(core_rst_n_local),
		.tag_push_i(tag_push),
		.tag_i(tag),
		.tag_full_o(tag_full),
		.tcm_rsp_valid_i(tcm_rsp_valid),
		.tcm_rsp_i(tcm_rsp),
		.tcm_rsp_ready_o(tcm_rsp_ready),
		.timer_rsp_valid_i(timer_rsp_valid),
		.timer_rsp_i(timer_rsp),
		.timer_rsp_ready_o(timer_rsp_ready),
		.ext_rsp_valid_i(ext_rsp_valid_i),
		.ext_rsp_i(ext_rsp_i),
		.ext_rsp_ready_o(ext_rsp_ready_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_o(rsp_o),
		.rsp_ready_i(rsp_ready_i)
	);

endmodule

`default_nettype wire

// File: hdl/dmem_tcm.sv
// Tightly coupled data RAM with byte-lane writes; answers every access one cycle later.
`default_nettype none

module dmem_tcm
	import dmem_pkg::*;
#(
	parameter int unsigned DEPTH = 16384
) (
	input  wire       clk,
	input  wire       core_rst_n_local,
	input  wire       req_valid_i,
	input  dmem_req_t req_i,
	output logic      req_ready_o,
	output logic      rsp_valid_o,
	output dmem_rsp_t rsp_o,
	input  wire       rsp_ready_i
);

	localparam int unsigned IDX_W = $clog2(DEPTH);

	dmem_data_t       mem [DEPTH];
	logic [IDX_W-1:0] idx;
	logic [3:0]       wr_be;
	dmem_data_t       wr_data;
	logic             req_fire;
	logic             rsp_valid_q;
	dmem_rsp_t        rsp_q;

	assign idx         = req_i.addr[IDX_W+1:2];
	assign req_ready_o = ~rsp_valid_q | rsp_ready_i; // accept while the response drains.
	assign req_fire    = req_valid_i & req_ready_o;

	always_comb begin
		case (req_i.width)
			DMEM_WIDTH_BYTE: begin
				wr_be   = 4'b0001 << req_i.addr[1:0];
				wr_data = {4{req_i.wdata[7:0]}};
			end
			DMEM_WIDTH_HALF: begin
				wr_be   = 4'b0011 << {req_i.addr[1], 1'b0};
				wr_data = {2{req_i.wdata[15:0]}};
			end
			default: begin
				wr_be   = 4'b1111;
				wr_data = req_i.wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (req_fire && req_i.cmd == DMEM_CMD_WR) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_be[b]) mem[idx][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			rsp_q.rdata <= (req_i.cmd == DMEM_CMD_RD) ? mem[idx] : '0; // writes return zero.
			rsp_q.resp  <= DMEM_RESP_OK;
		end
	end

	always_ff @(posedge clk) begin
		if (!core_rst_n_local) rsp_valid_q <= 1'b0;
		else if (req_fire) rsp_valid_q <= 1'b1;
		else if (rsp_ready_i) rsp_valid_q <= 1'b0;
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: hdl/dmem_timer.sv
// Memory-mapped machine timer with mtime, mtimecmp, an enable bit and the timer interrupt.
`default_nettype none

module dmem_timer
	import dmem_pkg::*;
(
	input  wire       clk,
	input  wire       core_rst_n_local,
	input  wire       req_valid_i,
	input  dmem_req_t req_i,
	output logic      req_ready_o,
	output logic      rsp_valid_o,
	output dmem_rsp_t rsp_o,
	input  wire       rsp_ready_i,
	output logic      timer_irq_o
);

	dmem_tmr_off_t offset;
	logic          req_fire;
	logic          wr_en;
	logic          hit;
	dmem_data_t    rd_data;
	logic          enable_q;
	logic [63:0]   mtime_q;
	logic [63:0]   mtimecmp_q;
	logic          rsp_valid_q;
	dmem_rsp_t     rsp_q;

	assign offset      = req_i.addr[4:0];
	assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
	assign req_fire    = req_valid_i & req_ready_o;
	assign wr_en       = req_fire & (req_i.cmd == DMEM_CMD_WR) & hit;

	always_comb begin
		hit = 1'b1;
		case (offset)
			DMEM_TMR_CTRL:     rd_data = {31'd0, enable_q};
			DMEM_TMR_MTIME_LO: rd_data = mtime_q[31:0];
			DMEM_TMR_MTIME_HI: rd_data = mtime_q[63:32];
			DMEM_TMR_CMP_LO:   rd_data = mtimecmp_q[31:0];
			DMEM_TMR_CMP_HI:   rd_data = mtimecmp_q[63:32];
			default: begin
				hit     = 1'b0;
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!core_rst_n_local) begin
			enable_q   <= 1'b0;
			mtime_q    <= '0;
			mtimecmp_q <= '1;
		end else begin
			if (wr_en && offset == DMEM_TMR_CTRL) enable_q <= req_i.wdata[0];
			if (wr_en && offset == DMEM_TMR_MTIME_LO) mtime_q[31:0] <= req_i.wdata;
			else if (wr_en && offset == DMEM_TMR_MTIME_HI) mtime_q[63:32] <= req_i.wdata;
			else if (enable_q) mtime_q <= mtime_q + 64'd1; // a write wins over the tick.
			if (wr_en && offset == DMEM_TMR_CMP_LO) mtimecmp_q[31:0] <= req_i.wdata;
			if (wr_en && offset == DMEM_TMR_CMP_HI) mtimecmp_q[63:32] <= req_i.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			rsp_q.rdata <= (req_i.cmd == DMEM_CMD_RD) ? rd_data : '0;
			rsp_q.resp  <= hit ? DMEM_RESP_OK : DMEM_RESP_ERR;
		end
	end

	always_ff @(posedge clk) begin
		if (!core_rst_n_local) rsp_valid_q <= 1'b0;
		else if (req_fire) rsp_valid_q <= 1'b1;
		else if (rsp_ready_i) rsp_valid_q <= 1'b0;
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;
	assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// File: tb/dmem_subsys_properties.sv
// Handshake and reset checks for the data-memory subsystem; bound into the top level by bind.
`default_nettype none

module dmem_subsys_properties
	import dmem_pkg::*;
(
	input  wire       clk,
	input  wire       core_rst_n_local,
	input  wire       rsp_valid_o,
	input  wire       rsp_ready_i,
	input  dmem_rsp_t rsp_o,
	input  wire       ext_req_valid_o,
	input  wire       ext_req_ready_i,
	input  dmem_req_t ext_req_o,
	input  wire       timer_irq_o
);

	rsp_hold: assert property (@(posedge clk) disable iff (!core_rst_n_local)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
		else $error("core response changed while stalled");

	ext_req_hold: assert property (@(posedge clk) disable iff (!core_rst_n_local)
		ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o && $stable(ext_req_o))
		else $error("external request changed while stalled");

	// first cycle out of reset sees the cleared state.
	reset_quiet: assert property (@(posedge clk)
		$rose(core_rst_n_local) |-> !rsp_valid_o && !ext_req_valid_o && !timer_irq_o)
		else $error("valid or interrupt output high after reset");

endmodule

bind dmem_subsys_top dmem_subsys_properties props (.*);

`default_nettype wire

// File: tb/dmem_subsys_tb.sv
// Table-driven testbench for the data-memory subsystem; simulate it as the top module.
`default_nettype none

module dmem_subsys_tb
	import dmem_pkg::*;
();

	typedef enum logic [2:0] {CK_DATA, CK_MARK, CK_INCR, CK_IRQ_HI, CK_IRQ_LO} chk_e;

	typedef struct {
		int        test;
		dmem_req_t req;
		dmem_rsp_t exp;
		chk_e      chk;
	} row_t;

	localparam int          NUM_TESTS = 6;
	localparam dmem_cmd_e   RD = DMEM_CMD_RD;
	localparam dmem_cmd_e   WR = DMEM_CMD_WR;
	localparam dmem_width_e B  = DMEM_WIDTH_BYTE;
	localparam dmem_width_e H  = DMEM_WIDTH_HALF;
	localparam dmem_width_e W  = DMEM_WIDTH_WORD;
	localparam dmem_resp_e  OK = DMEM_RESP_OK;
	localparam dmem_resp_e  ER = DMEM_RESP_ERR;

	logic       clk;
	logic       core_rst_n_local;
	logic       req_valid_i;
	logic       req_ready_o;
	dmem_req_t  req_i;
	logic       rsp_valid_o;
	logic       rsp_ready_i;
	dmem_rsp_t  rsp_o;
	logic       ext_req_valid_o;
	logic       ext_req_ready_i;
	dmem_req_t  ext_req_o;
	logic       ext_rsp_valid_i;
	logic       ext_rsp_ready_o;
	dmem_rsp_t  ext_rsp_i;
	logic       timer_irq_o;

	row_t        rows [$];
	int          sb [$]; // row indices in acceptance order.
	int          test_errs [NUM_TESTS+1];
	int          errors;
	int          checked;
	int          tests_done;
	int          tests_failed;
	int unsigned ext_delay; // next response delay of the external model.
	dmem_data_t  last_mtime;
	dmem_data_t  ext_mem [dmem_addr_t];

	dmem_subsys_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic next_slot();
		@(posedge clk);
		#2;
	endtask

	task automatic add_row(input int t, input dmem_cmd_e c, input dmem_width_e w,
			input dmem_addr_t a, input dmem_data_t wd, input dmem_data_t ed,
			input dmem_resp_e er, input chk_e k);
		row_t r;
		r.test = t;
		r.req  = '{cmd: c, width: w, addr: a, wdata: wd};
		r.exp  = '{rdata: ed, resp: er};
		r.chk  = k;
		rows.push_back(r);
	endtask

	function automatic string test_name(input int t);
		case (t)
			1: return "tcm word and lane writes";
			2: return "external port access";
			3: return "mixed ports in order";
			4: return "misaligned rejection";
			5: return "timer registers and irq";
			default: return "timer enable and unmapped offset";
		endcase
	endfunction

	function automatic bit is_aligned(input dmem_req_t r);
		if (r.width == DMEM_WIDTH_HALF) return !r.addr[0];
		if (r.width == DMEM_WIDTH_WORD) return r.addr[1:0] == 2'b00;
		return 1'b1;
	endfunction

	function automatic dmem_data_t ext_read(input dmem_addr_t a);
		dmem_addr_t wa;
		wa = {a[31:2], 2'b00};
		if (ext_mem.exists(wa)) return ext_mem[wa];
		return wa ^ 32'h5A5A_5A5A; // unwritten words hold an address pattern.
	endfunction

	function automatic dmem_data_t merge_lanes(input dmem_data_t old, input dmem_req_t r);
		dmem_data_t v;
		v = old;
		case (r.width)
			DMEM_WIDTH_BYTE: v[8*r.addr[1:0] +: 8] = r.wdata[7:0];
			DMEM_WIDTH_HALF: v[16*r.addr[1] +: 16] = r.wdata[15:0];
			default:         v = r.wdata;
		endcase
		return v;
	endfunction

	task automatic load_table();
		add_row(1, WR, W, 32'hF000_0010, 32'h1122_3344, 32'h0, OK, CK_DATA);
		add_row(1, RD, W, 32'hF000_0010, 32'h0, 32'h1122_3344, OK, CK_DATA);
		add_row(1, WR, W, 32'hF000_0014, 32'hA5A5_5A5A, 32'h0, OK, CK_DATA);
		add_row(1, RD, W, 32'hF000_0014, 32'h0, 32'hA5A5_5A5A, OK, CK_DATA);
		add_row(1, WR, B, 32'hF000_0011, 32'h0000_00EE, 32'h0, OK, CK_DATA);
		add_row(1, WR, H, 32'hF000_0012, 32'h0000_BEEF, 32'h0, OK, CK_DATA);
		add_row(1, RD, W, 32'hF000_0010, 32'h0, 32'hBEEF_EE44, OK, CK_DATA);
		add_row(1, WR, B, 32'hF000_0017, 32'h0000_0077, 32'h0, OK, CK_DATA);
		add_row(1, RD, W, 32'hF000_0014, 32'h0, 32'h77A5_5A5A, OK, CK_DATA);
		add_row(2, WR, W, 32'h8000_0000, 32'hCAFE_F00D, 32'h0, OK, CK_DATA);
		add_row(2, RD, W, 32'h8000_0000, 32'h0, 32'hCAFE_F00D, OK, CK_DATA);
		add_row(2, RD, W, 32'h0000_1000, 32'h0, 32'h5A5A_4A5A, OK, CK_DATA);
		add_row(2, WR, H, 32'h8000_0002, 32'h0000_1234, 32'h0, OK, CK_DATA);
		add_row(2, RD, W, 32'h8000_0000, 32'h0, 32'h1234_F00D, OK, CK_DATA);
		add_row(3, WR, W, 32'hF000_0100, 32'h0000_0001, 32'h0, OK, CK_DATA);
		add_row(3, WR, W, 32'h8000_0100, 32'h0000_0002, 32'h0, OK, CK_DATA);
		add_row(3, RD, W, 32'h8000_0100, 32'h0, 32'h0000_0002, OK, CK_DATA);
		add_row(3, RD, W, 32'hF000_0100, 32'h0, 32'h0000_0001, OK, CK_DATA);
		add_row(3, RD, W, 32'h8000_0000, 32'h0, 32'h1234_F00D, OK, CK_DATA);
		add_row(3, RD, W, 32'hF000_0010, 32'h0, 32'hBEEF_EE44, OK, CK_DATA);
		add_row(3, RD, W, 32'h8000_0010, 32'h0, 32'hDA5A_5A4A, OK, CK_DATA);
		add_row(3, RD, W, 32'hF000_0014, 32'h0, 32'h77A5_5A5A, OK, CK_DATA);
		add_row(4, RD, W, 32'h8000_0001, 32'h0, 32'h0, ER, CK_DATA);
		add_row(4, WR, H, 32'h8000_0003, 32'h0000_FFFF, 32'h0, ER, CK_DATA);
		add_row(4, RD, W, 32'hF000_0002, 32'h0, 32'h0, ER, CK_DATA);
		add_row(4, RD, W, 32'h8000_0000, 32'h0, 32'h1234_F00D, OK, CK_DATA);
		add_row(5, WR, W, 32'hF004_0008, 32'h0000_1000, 32'h0, OK, CK_DATA);
		add_row(5, WR, W, 32'hF004_000C, 32'h0000_0002, 32'h0, OK, CK_DATA);
		add_row(5, RD, W, 32'hF004_0008, 32'h0, 32'h0000_1000, OK, CK_DATA);
		add_row(5, RD, W, 32'hF004_000C, 32'h0, 32'h0000_0002, OK, CK_DATA);
		add_row(5, WR, W, 32'hF004_0014, 32'h0000_0001, 32'h0, OK, CK_IRQ_HI);
		add_row(5, RD, W, 32'hF004_0014, 32'h0, 32'h0000_0001, OK, CK_IRQ_HI);
		add_row(5, WR, W, 32'hF004_0014, 32'hFFFF_FFFF, 32'h0, OK, CK_IRQ_LO);
		add_row(6, WR, W, 32'hF004_0000, 32'h0000_0001, 32'h0, OK, CK_DATA);
		add_row(6, RD, W, 32'hF004_0000, 32'h0, 32'h0000_0001, OK, CK_DATA);
		add_row(6, RD, W, 32'hF004_0008, 32'h0, 32'h0, OK, CK_MARK);
		add_row(6, RD, W, 32'hF004_0008, 32'h0, 32'h0, OK, CK_INCR);
		add_row(6, RD, W, 32'hF004_0018, 32'h0, 32'h0, ER, CK_DATA);
	endtask

	// ========================================================================
	// external memory model, one request at a time
	// ========================================================================
	initial begin : ext_model
		dmem_req_t   r;
		int unsigned delay;
		ext_req_ready_i = 1'b0;
		ext_rsp_valid_i = 1'b0;
		ext_rsp_i       = '0;
		wait (core_rst_n_local);
		next_slot();
		ext_req_ready_i = 1'b1;
		forever begin
			@(negedge clk);
			if (ext_req_valid_o && ext_req_ready_i) begin
				r     = ext_req_o;
				delay = ext_delay;
				assert (is_aligned(r)) else begin
					$display("FAIL %0t: misaligned request at %h reached the external port",
						$time, r.addr);
					errors++;
				end
				next_slot();
				ext_req_ready_i = 1'b0;
				ext_rsp_i.rdata = (r.cmd == DMEM_CMD_RD) ? ext_read(r.addr) : '0;
				ext_rsp_i.resp  = DMEM_RESP_OK;
				if (r.cmd == DMEM_CMD_WR) begin
					ext_mem[{r.addr[31:2], 2'b00}] = merge_lanes(ext_read(r.addr), r);
				end
				repeat (delay) next_slot();
				ext_rsp_valid_i = 1'b1;
				do @(negedge clk); while (!ext_rsp_ready_o);
				next_slot();
				ext_rsp_valid_i = 1'b0;
				ext_req_ready_i = 1'b1;
			end
		end
	end

	initial begin : backpressure
		void'($urandom(99880));
		rsp_ready_i = 1'b0;
		ext_delay   = 0;
		wait (core_rst_n_local);
		forever begin
			next_slot();
			rsp_ready_i = ($urandom_range(3, 0) != 0); // ready about three cycles in four.
			ext_delay   = $urandom_range(3, 0);
		end
	end

	// ========================================================================
	// response checker
	// ========================================================================
	always @(negedge clk) begin : monitor
		int   idx;
		row_t r;
		logic ok;
		if (core_rst_n_local && rsp_valid_o && rsp_ready_i) begin
			assert (sb.size() > 0) else begin
				$display("a response arrived with no request outstanding at time %0t", $time);
				errors++;
			end
			if (sb.size() > 0) begin
				idx = sb.pop_front();
				r   = rows[idx];
				case (r.chk)
					CK_MARK:   ok = (rsp_o.resp == r.exp.resp);
					CK_INCR:   ok = (rsp_o.resp == r.exp.resp) && (rsp_o.rdata > last_mtime);
					CK_IRQ_HI: ok = (rsp_o == r.exp) && timer_irq_o;
					CK_IRQ_LO: ok = (rsp_o == r.exp) && !timer_irq_o;
					default:   ok = (rsp_o == r.exp);
				endcase
				if (r.chk == CK_MARK || r.chk == CK_INCR) last_mtime = rsp_o.rdata;
				assert (ok) else begin
					$display("FAIL %0t: row %0d got rdata %h resp %0d irq %b, expected %h resp %0d",
						$time, idx, rsp_o.rdata, rsp_o.resp, timer_irq_o,
						r.exp.rdata, r.exp.resp);
					test_errs[r.test]++;
					errors++;
				end
				checked++;
				if (checked == rows.size() || rows[checked].test != r.test) begin
					tests_done++;
					if (test_errs[r.test] != 0) tests_failed++;
					$display("test %0d %s: %s", r.test, test_name(r.test),
						(test_errs[r.test] == 0) ? "passed" : "failed");
				end
			end
		end
	end

	initial begin : watchdog
		wait (core_rst_n_local);
		repeat (rows.size() * 50) @(posedge clk);
		$display("timeout: responses still missing after %0d cycles", rows.size() * 50);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : main
		core_rst_n_local = 1'b0;
		req_valid_i      = 1'b0;
		req_i            = '0;
		errors           = 0;
		checked          = 0;
		tests_done       = 0;
		tests_failed     = 0;
		last_mtime       = '0;
		foreach (test_errs[t]) test_errs[t] = 0;
		load_table();
		repeat (4) @(posedge clk);
		#2;
		core_rst_n_local = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			req_valid_i = 1'b1;
			req_i       = rows[i].req;
			do @(negedge clk); while (!req_ready_o);
			sb.push_back(i);
			next_slot();
		end
		req_valid_i = 1'b0;
		wait (checked == rows.size());
		$display("%0d tests run, %0d failed, %0d rows checked, %0d errors",
			tests_done, tests_failed, checked, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
